//--- include/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

`define XLEN            32
`define MEM_DEPTH_WORDS 256
`define MEM_LATENCY     2   // accept to response strobe

// mcause codes for memory faults
`define CAUSE_LOAD_ACCESS  5
`define CAUSE_STORE_ACCESS 7
`define CAUSE_LOAD_PAGE    13
`define CAUSE_STORE_PAGE   15

`endif

//--- src/mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE,
        MEM_ATOMIC
    } mem_sel_e;

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } mem_size_e;

    typedef enum logic {
        OP_UNSIGNED,
        OP_SIGNED
    } sign_sel_e;

    // min/max signedness lives in the encoding itself
    typedef enum logic [3:0] {
        A_LR,
        A_SC,
        A_SWAP,
        A_ADD,
        A_XOR,
        A_AND,
        A_OR,
        A_MIN,
        A_MAX,
        A_MINU,
        A_MAXU
    } aext_sel_e;

    typedef enum logic {
        ERR_ACCESS,
        ERR_PAGE
    } err_type_e;

    typedef union packed {
        logic [`XLEN-1:0]           word;
        logic [`XLEN/8-1:0][7:0]    bytes;
        logic [`XLEN/16-1:0][15:0]  halves;
    } mem_word_u;

endpackage

//--- src/amo_alu.sv
`include "mem_defs.svh"

module amo_alu (
    input  mem_pkg::aext_sel_e a_sel,
    input  logic [`XLEN-1:0]   old_data,
    input  logic [`XLEN-1:0]   rs2_data,
    output logic [`XLEN-1:0]   new_data
);

    logic lt_s;
    logic lt_u;

    assign lt_s = $signed(old_data) < $signed(rs2_data);
    assign lt_u = old_data < rs2_data;

    always_comb begin
        case (a_sel)
            mem_pkg::A_ADD:  new_data = old_data + rs2_data;
            mem_pkg::A_XOR:  new_data = old_data ^ rs2_data;
            mem_pkg::A_AND:  new_data = old_data & rs2_data;
            mem_pkg::A_OR:   new_data = old_data | rs2_data;
            mem_pkg::A_MIN:  new_data = lt_s ? old_data : rs2_data;
            mem_pkg::A_MAX:  new_data = lt_s ? rs2_data : old_data;
            mem_pkg::A_MINU: new_data = lt_u ? old_data : rs2_data;
            mem_pkg::A_MAXU: new_data = lt_u ? rs2_data : old_data;
            // swap stores rs2 unchanged
            default:         new_data = rs2_data;
        endcase
    end

endmodule

//--- src/load_format.sv
`include "mem_defs.svh"

module load_format (
    input  mem_pkg::mem_sel_e  mem_sel,
    input  mem_pkg::mem_size_e mem_size,
    input  mem_pkg::sign_sel_e sign_sel,
    input  mem_pkg::aext_sel_e a_sel,
    input  logic [1:0]         byte_offset,
    input  mem_pkg::mem_word_u mem_word,
    input  logic               sc_fail,
    output logic [`XLEN-1:0]   rdata
);

    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    logic        ext_b;
    logic        ext_h;

    assign lane_b = mem_word.bytes[byte_offset];
    assign lane_h = mem_word.halves[byte_offset[1]];   // offset bit 0 ignored
    assign ext_b  = (sign_sel == mem_pkg::OP_SIGNED) & lane_b[7];
    assign ext_h  = (sign_sel == mem_pkg::OP_SIGNED) & lane_h[15];

    always_comb begin
        case (mem_sel)
            mem_pkg::MEM_LOAD: begin
                case (mem_size)
                    mem_pkg::SIZE_B: rdata = {{(`XLEN-8){ext_b}}, lane_b};
                    mem_pkg::SIZE_H: rdata = {{(`XLEN-16){ext_h}}, lane_h};
                    default:         rdata = mem_word.word;
                endcase
            end
            mem_pkg::MEM_ATOMIC: begin
                if (a_sel == mem_pkg::A_SC)
                    rdata = {{(`XLEN-1){1'b0}}, sc_fail};   // 0 on success
                else
                    rdata = mem_word.word;   // lr and amo old value
            end
            default: rdata = '0;   // stores return nothing
        endcase
    end

endmodule

//--- src/mem_stage.sv
`include "mem_defs.svh"

module mem_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid,
    input  mem_pkg::mem_sel_e   mem_sel,
    input  mem_pkg::mem_size_e  mem_size,
    input  mem_pkg::sign_sel_e  sign_sel,
    input  mem_pkg::aext_sel_e  a_sel,
    input  logic [`XLEN-1:0]    addr,
    input  logic [`XLEN-1:0]    rs2_data,
    input  logic                req_ready,
    input  logic                resp_valid,
    input  logic [`XLEN-1:0]    resp_rdata,
    input  logic                resp_error,
    input  mem_pkg::err_type_e  resp_errty,
    output logic                stall,
    output logic [`XLEN-1:0]    rdata,
    output logic                trap_valid,
    output logic [`XLEN-1:0]    trap_cause,
    output logic                req_valid,
    output logic                req_wen,
    output logic [`XLEN-1:0]    req_addr,
    output logic [`XLEN-1:0]    req_wdata,
    output mem_pkg::mem_size_e  req_size
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_READY,
        S_WAIT_READ,
        S_WAIT_WRITE
    } state_e;

    state_e              state;
    logic                done_q;     // completion cycle marker
    logic                amo_wr;     // amo rewritten to its store half
    logic                err_q;
    mem_pkg::err_type_e  errty_q;
    logic                sc_fail_q;
    mem_pkg::mem_word_u  rdata_q;
    logic                resv_valid;
    logic [`XLEN-1:0]    resv_addr;

    logic                is_atomic;
    logic                is_sc;
    logic                is_lr;
    logic                is_amo;
    logic                store_kind;
    logic                sc_hit;
    logic [`XLEN-1:0]    amo_data;

    assign is_atomic  = mem_sel == mem_pkg::MEM_ATOMIC;
    assign is_sc      = is_atomic && a_sel == mem_pkg::A_SC;
    assign is_lr      = is_atomic && a_sel == mem_pkg::A_LR;
    assign is_amo     = is_atomic && !is_sc && !is_lr;
    assign store_kind = mem_sel == mem_pkg::MEM_STORE || (is_atomic && !is_lr);
    assign sc_hit     = resv_valid && resv_addr == addr;

    assign stall = valid && (state != S_IDLE || (!done_q && mem_sel != mem_pkg::MEM_NONE));

    assign req_valid = valid && state == S_WAIT_READY;
    assign req_wen   = amo_wr || mem_sel == mem_pkg::MEM_STORE || is_sc;
    assign req_addr  = addr;
    assign req_wdata = is_amo ? amo_data : rs2_data;
    assign req_size  = is_atomic ? mem_pkg::SIZE_W : mem_size;

    amo_alu u_amo_alu (
        .a_sel    (a_sel),
        .old_data (rdata_q.word),
        .rs2_data (rs2_data),
        .new_data (amo_data)
    );

    load_format u_load_format (
        .mem_sel     (mem_sel),
        .mem_size    (mem_size),
        .sign_sel    (sign_sel),
        .a_sel       (a_sel),
        .byte_offset (addr[1:0]),
        .mem_word    (rdata_q),
        .sc_fail     (sc_fail_q),
        .rdata       (rdata)
    );

    assign trap_valid = done_q && err_q;

    always_comb begin
        trap_cause = '0;
        if (trap_valid) begin
            if (errty_q == mem_pkg::ERR_PAGE)
                trap_cause = store_kind ? `CAUSE_STORE_PAGE : `CAUSE_LOAD_PAGE;
            else
                trap_cause = store_kind ? `CAUSE_STORE_ACCESS : `CAUSE_LOAD_ACCESS;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            done_q     <= 1'b0;
            amo_wr     <= 1'b0;
            err_q      <= 1'b0;
            sc_fail_q  <= 1'b0;
            resv_valid <= 1'b0;
        end else if (!valid || mem_sel == mem_pkg::MEM_NONE || done_q) begin
            state  <= S_IDLE;
            done_q <= 1'b0;
            amo_wr <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    err_q     <= 1'b0;
                    sc_fail_q <= 1'b0;
                    if (is_sc) begin
                        resv_valid <= 1'b0;   // consumed either way
                        if (sc_hit) begin
                            state <= S_WAIT_READY;
                        end else begin
                            sc_fail_q <= 1'b1;
                            done_q    <= 1'b1;
                        end
                    end else begin
                        if (is_lr) begin
                            resv_valid <= 1'b1;
                            resv_addr  <= addr;
                        end
                        state <= S_WAIT_READY;
                    end
                end
                S_WAIT_READY: begin
                    if (req_ready)
                        state <= req_wen ? S_WAIT_WRITE : S_WAIT_READ;
                end
                S_WAIT_READ: begin
                    if (resp_valid) begin
                        rdata_q <= resp_rdata;
                        err_q   <= resp_error;
                        errty_q <= resp_errty;
                        if (is_amo && !resp_error) begin
                            amo_wr <= 1'b1;
                            state  <= S_WAIT_READY;
                        end else begin
                            state  <= S_IDLE;
                            done_q <= 1'b1;
                        end
                    end
                end
                default: begin   // write response
                    if (resp_valid) begin
                        err_q   <= resp_error;
                        errty_q <= resp_errty;
                        state   <= S_IDLE;
                        done_q  <= 1'b1;
                    end
                end
            endcase
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req_addr));

    a_resp_state: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> state == S_WAIT_READ || state == S_WAIT_WRITE);

endmodule

//--- src/data_mem.sv
`include "mem_defs.svh"

module data_mem (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  logic                req_wen,
    input  logic [`XLEN-1:0]    req_addr,
    input  logic [`XLEN-1:0]    req_wdata,
    input  mem_pkg::mem_size_e  req_size,
    output logic                req_ready,
    output logic                resp_valid,
    output logic [`XLEN-1:0]    resp_rdata,
    output logic                resp_error,
    output mem_pkg::err_type_e  resp_errty
);

    localparam int IDX_W = $clog2(`MEM_DEPTH_WORDS);
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    mem_pkg::mem_word_u  mem [`MEM_DEPTH_WORDS];
    mem_pkg::mem_word_u  wr_word;
    logic [IDX_W-1:0]    idx;
    logic [1:0]          off;
    logic                page_fault;
    logic                access_fault;
    logic                accept;
    logic                busy;
    logic [CNT_W-1:0]    cnt;

    initial begin
        for (int i = 0; i < `MEM_DEPTH_WORDS; i++)
            mem[i] = '0;
    end

    assign idx          = req_addr[IDX_W+1:2];
    assign off          = req_addr[1:0];
    assign page_fault   = req_addr[`XLEN-1];
    assign access_fault = !page_fault && req_addr[`XLEN-1:2] >= `MEM_DEPTH_WORDS;
    assign accept       = req_valid && req_ready;

    assign req_ready  = !busy;
    assign resp_valid = busy && cnt == '0;

    // merge store data into the addressed lane
    always_comb begin
        wr_word = mem[idx];
        case (req_size)
            mem_pkg::SIZE_B: wr_word.bytes[off] = req_wdata[7:0];
            mem_pkg::SIZE_H: wr_word.halves[off[1]] = req_wdata[15:0];
            default:         wr_word.word = req_wdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(`MEM_LATENCY - 1);
        end else if (busy) begin
            if (cnt == '0)
                busy <= 1'b0;
            else
                cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_error <= page_fault || access_fault;
            resp_errty <= page_fault ? mem_pkg::ERR_PAGE : mem_pkg::ERR_ACCESS;
            resp_rdata <= (page_fault || access_fault) ? '0 : mem[idx].word;
            if (req_wen && !page_fault && !access_fault)
                mem[idx] <= wr_word;
        end
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> (!accept && !resp_valid) [*(`MEM_LATENCY-1)] ##1 (resp_valid && !accept));

endmodule

//--- src/mem_subsys_top.sv
`include "mem_defs.svh"

module mem_subsys_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid,
    input  mem_pkg::mem_sel_e   mem_sel,
    input  mem_pkg::mem_size_e  mem_size,
    input  mem_pkg::sign_sel_e  sign_sel,
    input  mem_pkg::aext_sel_e  a_sel,
    input  logic [`XLEN-1:0]    addr,
    input  logic [`XLEN-1:0]    rs2_data,
    output logic                stall,
    output logic [`XLEN-1:0]    rdata,
    output logic                trap_valid,
    output logic [`XLEN-1:0]    trap_cause
);

    logic                req_valid;
    logic                req_wen;
    logic [`XLEN-1:0]    req_addr;
    logic [`XLEN-1:0]    req_wdata;
    mem_pkg::mem_size_e  req_size;
    logic                req_ready;
    logic                resp_valid;
    logic [`XLEN-1:0]    resp_rdata;
    logic                resp_error;
    mem_pkg::err_type_e  resp_errty;

    mem_stage u_mem_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid      (valid),
        .mem_sel    (mem_sel),
        .mem_size   (mem_size),
        .sign_sel   (sign_sel),
        .a_sel      (a_sel),
        .addr       (addr),
        .rs2_data   (rs2_data),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .resp_error (resp_error),
        .resp_errty (resp_errty),
        .stall      (stall),
        .rdata      (rdata),
        .trap_valid (trap_valid),
        .trap_cause (trap_cause),
        .req_valid  (req_valid),
        .req_wen    (req_wen),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_size   (req_size)
    );

    data_mem u_data_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_wen    (req_wen),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_size   (req_size),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .resp_error (resp_error),
        .resp_errty (resp_errty)
    );

endmodule

//--- test/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;   // released just after the third edge
    end

endmodule

//--- test/tb_mem_subsys.sv
`include "mem_defs.svh"

module tb_mem_subsys;

    localparam int RAND_OPS       = 200;
    localparam int TIMEOUT_CYCLES = RAND_OPS * 10 + 500;

    logic                clk;
    logic                rst_n;
    logic                valid;
    mem_pkg::mem_sel_e   mem_sel;
    mem_pkg::mem_size_e  mem_size;
    mem_pkg::sign_sel_e  sign_sel;
    mem_pkg::aext_sel_e  a_sel;
    logic [`XLEN-1:0]    addr;
    logic [`XLEN-1:0]    rs2_data;
    logic                stall;
    logic [`XLEN-1:0]    rdata;
    logic                trap_valid;
    logic [`XLEN-1:0]    trap_cause;

    logic [`XLEN-1:0]    shadow_mem [`MEM_DEPTH_WORDS];
    logic                shadow_resv_valid;
    logic [`XLEN-1:0]    shadow_resv_addr;
    logic [`XLEN-1:0]    exp_rdata_q [$];
    logic                exp_trap_q [$];
    logic [`XLEN-1:0]    exp_cause_q [$];
    logic [`XLEN-1:0]    cmp_rdata;
    logic                cmp_trap;
    logic [`XLEN-1:0]    cmp_cause;
    logic [31:0]         rng_state;
    int                  errors;
    int                  checks;
    int                  cycle_count;

    tb_clock u_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_subsys_top u_mem_subsys_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid      (valid),
        .mem_sel    (mem_sel),
        .mem_size   (mem_size),
        .sign_sel   (sign_sel),
        .a_sel      (a_sel),
        .addr       (addr),
        .rs2_data   (rs2_data),
        .stall      (stall),
        .rdata      (rdata),
        .trap_valid (trap_valid),
        .trap_cause (trap_cause)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // value written back by an AMO
    function automatic logic [31:0] amo_expect(input mem_pkg::aext_sel_e op,
                                               input logic [31:0] old, input logic [31:0] src);
        case (op)
            mem_pkg::A_ADD:  return old + src;
            mem_pkg::A_XOR:  return old ^ src;
            mem_pkg::A_AND:  return old & src;
            mem_pkg::A_OR:   return old | src;
            mem_pkg::A_MIN:  return ($signed(old) < $signed(src)) ? old : src;
            mem_pkg::A_MAX:  return ($signed(old) > $signed(src)) ? old : src;
            mem_pkg::A_MINU: return (old < src) ? old : src;
            mem_pkg::A_MAXU: return (old > src) ? old : src;
            default:         return src;
        endcase
    endfunction

    // reference model updating shadow memory and reservation
    function automatic void predict_op(input mem_pkg::mem_sel_e sel,
                                       input mem_pkg::mem_size_e size,
                                       input mem_pkg::sign_sel_e sgn,
                                       input mem_pkg::aext_sel_e op,
                                       input logic [31:0] a, input logic [31:0] d,
                                       output logic [31:0] e_rdata, output logic e_trap,
                                       output logic [31:0] e_cause);
        logic       page;
        logic       fault;
        logic       is_st;
        logic       touched;
        logic [7:0] idx;
        logic [31:0] old;
        logic [7:0]  b;
        logic [15:0] h;
        page    = a[31];
        fault   = page || (a[31:2] >= `MEM_DEPTH_WORDS);
        idx     = a[9:2];
        old     = shadow_mem[idx];
        b       = old[{a[1:0], 3'b000} +: 8];
        h       = old[{a[1], 4'b0000} +: 16];
        is_st   = sel == mem_pkg::MEM_STORE || (sel == mem_pkg::MEM_ATOMIC && op != mem_pkg::A_LR);
        touched = sel != mem_pkg::MEM_NONE;
        e_rdata = '0;
        e_trap  = 1'b0;
        e_cause = '0;
        case (sel)
            mem_pkg::MEM_LOAD: begin
                if (size == mem_pkg::SIZE_B)
                    e_rdata = {{24{sgn == mem_pkg::OP_SIGNED && b[7]}}, b};
                else if (size == mem_pkg::SIZE_H)
                    e_rdata = {{16{sgn == mem_pkg::OP_SIGNED && h[15]}}, h};
                else
                    e_rdata = old;
            end
            mem_pkg::MEM_STORE: begin
                if (!fault) begin
                    if (size == mem_pkg::SIZE_B)
                        shadow_mem[idx][{a[1:0], 3'b000} +: 8] = d[7:0];
                    else if (size == mem_pkg::SIZE_H)
                        shadow_mem[idx][{a[1], 4'b0000} +: 16] = d[15:0];
                    else
                        shadow_mem[idx] = d;
                end
            end
            mem_pkg::MEM_ATOMIC: begin
                if (op == mem_pkg::A_LR) begin
                    e_rdata           = old;
                    shadow_resv_valid = 1'b1;
                    shadow_resv_addr  = a;
                end else if (op == mem_pkg::A_SC) begin
                    if (shadow_resv_valid && shadow_resv_addr == a) begin
                        if (!fault)
                            shadow_mem[idx] = d;
                    end else begin
                        e_rdata = 32'd1;
                        touched = 1'b0;   // no access on a failed sc
                    end
                    shadow_resv_valid = 1'b0;
                end else begin
                    e_rdata = old;
                    if (!fault)
                        shadow_mem[idx] = amo_expect(op, old, d);
                end
            end
            default: ;
        endcase
        if (touched && fault) begin
            e_trap = 1'b1;
            if (page)
                e_cause = is_st ? `CAUSE_STORE_PAGE : `CAUSE_LOAD_PAGE;
            else
                e_cause = is_st ? `CAUSE_STORE_ACCESS : `CAUSE_LOAD_ACCESS;
        end
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h at time %0t", name, got, exp, $time);
        end
    endtask

    task automatic wait_complete();
        @(posedge clk);
        while (stall)
            @(posedge clk);
    endtask

    task automatic run_op(input mem_pkg::mem_sel_e sel, input mem_pkg::mem_size_e size,
                          input mem_pkg::sign_sel_e sgn, input mem_pkg::aext_sel_e op,
                          input logic [31:0] a, input logic [31:0] d);
        logic [31:0] e_rdata;
        logic        e_trap;
        logic [31:0] e_cause;
        predict_op(sel, size, sgn, op, a, d, e_rdata, e_trap, e_cause);
        exp_rdata_q.push_back(e_rdata);
        exp_trap_q.push_back(e_trap);
        exp_cause_q.push_back(e_cause);
        valid    = 1'b1;
        mem_sel  = sel;
        mem_size = size;
        sign_sel = sgn;
        a_sel    = op;
        addr     = a;
        rs2_data = d;
        if (sel == mem_pkg::MEM_NONE) begin
            #1;
            compare_value("stall", 32'(stall), 32'd0);   // no wait state expected
        end
        wait_complete();
        #1;
    endtask

    task automatic load_op(input mem_pkg::mem_size_e size, input mem_pkg::sign_sel_e sgn,
                           input logic [31:0] a);
        run_op(mem_pkg::MEM_LOAD, size, sgn, mem_pkg::A_LR, a, 32'h0);
    endtask

    task automatic store_op(input mem_pkg::mem_size_e size, input logic [31:0] a,
                            input logic [31:0] d);
        run_op(mem_pkg::MEM_STORE, size, mem_pkg::OP_UNSIGNED, mem_pkg::A_LR, a, d);
    endtask

    task automatic amo_op(input mem_pkg::aext_sel_e op, input logic [31:0] a,
                          input logic [31:0] d);
        run_op(mem_pkg::MEM_ATOMIC, mem_pkg::SIZE_W, mem_pkg::OP_UNSIGNED, op, a, d);
    endtask

    // result check at each completion edge
    always @(posedge clk) begin
        if (rst_n && valid && !stall) begin
            if (exp_trap_q.size() == 0) begin
                errors++;
                $display("operation completed with nothing expected at time %0t", $time);
            end else begin
                cmp_rdata = exp_rdata_q.pop_front();
                cmp_trap  = exp_trap_q.pop_front();
                cmp_cause = exp_cause_q.pop_front();
                compare_value("trap_valid", 32'(trap_valid), 32'(cmp_trap));
                compare_value("trap_cause", trap_cause, cmp_cause);
                if (!cmp_trap)
                    compare_value("rdata", rdata, cmp_rdata);
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: operations still running after %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [31:0]        r;
        logic [31:0]        d;
        logic [31:0]        a;
        mem_pkg::mem_sel_e  sel;
        mem_pkg::mem_size_e size;
        mem_pkg::aext_sel_e op;
        valid             = 1'b0;
        mem_sel           = mem_pkg::MEM_NONE;
        mem_size          = mem_pkg::SIZE_W;
        sign_sel          = mem_pkg::OP_UNSIGNED;
        a_sel             = mem_pkg::A_LR;
        addr              = '0;
        rs2_data          = '0;
        errors            = 0;
        checks            = 0;
        rng_state         = 32'd43702;
        shadow_resv_valid = 1'b0;
        shadow_resv_addr  = '0;
        for (int i = 0; i < `MEM_DEPTH_WORDS; i++)
            shadow_mem[i] = '0;
        wait (rst_n);
        @(posedge clk);
        #1;

        // every lane with both signs
        store_op(mem_pkg::SIZE_W, 32'h80, 32'h80ff7f01);
        for (int off = 0; off < 4; off++) begin
            load_op(mem_pkg::SIZE_B, mem_pkg::OP_SIGNED, 32'h80 + off);
            load_op(mem_pkg::SIZE_B, mem_pkg::OP_UNSIGNED, 32'h80 + off);
        end
        for (int off = 0; off < 4; off += 2) begin
            load_op(mem_pkg::SIZE_H, mem_pkg::OP_SIGNED, 32'h80 + off);
            load_op(mem_pkg::SIZE_H, mem_pkg::OP_UNSIGNED, 32'h80 + off);
        end
        load_op(mem_pkg::SIZE_W, mem_pkg::OP_SIGNED, 32'h80);
        store_op(mem_pkg::SIZE_B, 32'h85, 32'h123456f0);
        store_op(mem_pkg::SIZE_H, 32'h8a, 32'hdead9abc);
        load_op(mem_pkg::SIZE_W, mem_pkg::OP_UNSIGNED, 32'h84);
        load_op(mem_pkg::SIZE_W, mem_pkg::OP_UNSIGNED, 32'h88);
        load_op(mem_pkg::SIZE_H, mem_pkg::OP_SIGNED, 32'h8a);
        load_op(mem_pkg::SIZE_B, mem_pkg::OP_SIGNED, 32'h85);

        // lr/sc pairs
        store_op(mem_pkg::SIZE_W, 32'h100, 32'h11111111);
        amo_op(mem_pkg::A_SC, 32'h100, 32'h33333333);   // no reservation yet
        amo_op(mem_pkg::A_LR, 32'h100, 32'h0);
        amo_op(mem_pkg::A_SC, 32'h100, 32'h22222222);
        load_op(mem_pkg::SIZE_W, mem_pkg::OP_UNSIGNED, 32'h100);
        amo_op(mem_pkg::A_SC, 32'h100, 32'h44444444);
        amo_op(mem_pkg::A_LR, 32'h100, 32'h0);
        amo_op(mem_pkg::A_SC, 32'h104, 32'h55555555);
        amo_op(mem_pkg::A_SC, 32'h100, 32'h66666666);
        load_op(mem_pkg::SIZE_W, mem_pkg::OP_UNSIGNED, 32'h100);
        load_op(mem_pkg::SIZE_W, mem_pkg::OP_UNSIGNED, 32'h104);

        // amo kinds swap through maxu on negative and positive old words
        for (int k = 2; k <= 10; k++) begin
            op = mem_pkg::aext_sel_e'(k);
            store_op(mem_pkg::SIZE_W, 32'h200 + 8 * k, 32'hfffffff0);
            amo_op(op, 32'h200 + 8 * k, 32'h00000010);
            load_op(mem_pkg::SIZE_W, mem_pkg::OP_UNSIGNED, 32'h200 + 8 * k);
            store_op(mem_pkg::SIZE_W, 32'h204 + 8 * k, 32'h00000005);
            amo_op(op, 32'h204 + 8 * k, 32'h80000000);
            load_op(mem_pkg::SIZE_W, mem_pkg::OP_UNSIGNED, 32'h204 + 8 * k);
        end

        // faults
        load_op(mem_pkg::SIZE_W, mem_pkg::OP_UNSIGNED, 32'h400);
        store_op(mem_pkg::SIZE_W, 32'h400, 32'h01234567);
        amo_op(mem_pkg::A_ADD, 32'h7fc00000, 32'h1);
        load_op(mem_pkg::SIZE_W, mem_pkg::OP_UNSIGNED, 32'h80000010);
        store_op(mem_pkg::SIZE_B, 32'h80000011, 32'h000000aa);
        store_op(mem_pkg::SIZE_W, 32'h80000080, 32'hcafef00d);
        amo_op(mem_pkg::A_SWAP, 32'h80000000, 32'h5);
        load_op(mem_pkg::SIZE_W, mem_pkg::OP_UNSIGNED, 32'h80);
        amo_op(mem_pkg::A_LR, 32'h800, 32'h0);
        amo_op(mem_pkg::A_SC, 32'h800, 32'h7);   // reserved but out of range

        run_op(mem_pkg::MEM_NONE, mem_pkg::SIZE_W, mem_pkg::OP_UNSIGNED, mem_pkg::A_LR, 0, 0);
        run_op(mem_pkg::MEM_NONE, mem_pkg::SIZE_B, mem_pkg::OP_SIGNED, mem_pkg::A_ADD, 4, 9);

        for (int n = 0; n < RAND_OPS; n++) begin
            r    = next_rand();
            d    = next_rand();
            sel  = mem_pkg::mem_sel_e'(r[1:0]);
            size = mem_pkg::mem_size_e'(int'(r[5:4]) % 3);
            op   = mem_pkg::aext_sel_e'(int'(r[11:8]) % 11);
            if (sel == mem_pkg::MEM_ATOMIC)
                size = mem_pkg::SIZE_W;
            case (r[14:12])
                3'd0:    a = 32'h00000400;   // past the end
                3'd1:    a = 32'h80000000;
                default: a = 32'h0;
            endcase
            a[7:2] = r[21:16];
            if (size == mem_pkg::SIZE_B)
                a[1:0] = r[23:22];
            else if (size == mem_pkg::SIZE_H)
                a[1] = r[23];
            if (sel == mem_pkg::MEM_ATOMIC && op == mem_pkg::A_SC && r[24] && shadow_resv_valid)
                a = shadow_resv_addr;
            run_op(sel, size, mem_pkg::sign_sel_e'(r[6]), op, a, d);
        end

        valid   = 1'b0;
        mem_sel = mem_pkg::MEM_NONE;
        repeat (2) @(posedge clk);
        if (exp_trap_q.size() != 0) begin
            errors++;
            $display("%0d operations never completed", exp_trap_q.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
src/mem_pkg.sv
src/amo_alu.sv
src/load_format.sv
src/mem_stage.sv
src/data_mem.sv
src/mem_subsys_top.sv
test/tb_clock.sv
test/tb_mem_subsys.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mem_subsys
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@! grep -q "sim failed" $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
